// File: rtl/muldiv_pkg.sv
//----------------------------------------------------------------------------
// Widths, APB register map and divide step count of the RV32M coprocessor
// Opcode and controller state encodings
//----------------------------------------------------------------------------
package muldiv_pkg;

    localparam int XLEN      = 32;  // Operand and result width
    localparam int ADDR_W    = 5;   // APB address width
    localparam int DIV_STEPS = 32;  // One quotient bit per step
    localparam int STEP_W    = 5;   // Step counter width

    //------------------------------------------------------------------------
    // Register byte offsets
    //------------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] REG_SRC1   = 5'h00;
    localparam logic [ADDR_W-1:0] REG_SRC2   = 5'h04;
    localparam logic [ADDR_W-1:0] REG_CMD    = 5'h08;
    localparam logic [ADDR_W-1:0] REG_STATUS = 5'h0C;
    localparam logic [ADDR_W-1:0] REG_RESULT = 5'h10;

    // RV32M funct3 order, bit 2 set for the divide family
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } md_op_e;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        MUL_EXEC  = 3'd1,
        DIV_CHECK = 3'd2,
        DIV_EXEC  = 3'd3,
        RET       = 3'd4
    } md_state_e;

endpackage

// File: rtl/md_req_if.sv
//----------------------------------------------------------------------------
// Request and result channel between the register bank and the controller
//----------------------------------------------------------------------------
`timescale 1ns/10ps

interface md_req_if;

    logic                        start;  // One-cycle launch pulse
    muldiv_pkg::md_op_e          op;     // Stable while busy
    logic [muldiv_pkg::XLEN-1:0] src1;
    logic [muldiv_pkg::XLEN-1:0] src2;
    logic                        busy;
    logic [muldiv_pkg::XLEN-1:0] rslt;   // Valid while busy is low

    modport regs (
        output start, op, src1, src2,
        input  busy, rslt
    );

    modport ctrl (
        input  start, op,
        output busy, rslt
    );

endinterface

// File: rtl/step_counter.sv
//----------------------------------------------------------------------------
// Divide iteration counter, flags the final step
//----------------------------------------------------------------------------
`timescale 1ns/10ps

module step_counter (
    input  logic clk_i,
    input  logic rst_i,
    input  logic load_i,
    input  logic en_i,
    output logic last_o
);

    logic [muldiv_pkg::STEP_W-1:0] cnt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= (muldiv_pkg::STEP_W)'(muldiv_pkg::DIV_STEPS - 1);
        end else if (en_i) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign last_o = (cnt_q == '0);  // High during the last step

endmodule

// File: rtl/mul_datapath.sv
//----------------------------------------------------------------------------
// 33-bit signed multiplier with product register and word select
//----------------------------------------------------------------------------
`timescale 1ns/10ps

module mul_datapath (
    input  logic                        clk_i,
    input  logic                        load_i,
    input  muldiv_pkg::md_op_e          op_i,
    input  logic [muldiv_pkg::XLEN-1:0] src1_i,
    input  logic [muldiv_pkg::XLEN-1:0] src2_i,
    output logic [muldiv_pkg::XLEN-1:0] rslt_o
);

    logic                              src1_signed;
    logic                              src2_signed;
    logic signed [muldiv_pkg::XLEN:0]  src1_q;
    logic signed [muldiv_pkg::XLEN:0]  src2_q;
    logic                              high_q;
    logic signed [2*muldiv_pkg::XLEN+1:0] full;
    logic [2*muldiv_pkg::XLEN-1:0]     product_q;

    assign src1_signed = (op_i == muldiv_pkg::MULH) | (op_i == muldiv_pkg::MULHSU);
    assign src2_signed = (op_i == muldiv_pkg::MULH);
    assign full        = src1_q * src2_q;  // Extension bit makes one signed multiply

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            src1_q <= {src1_signed & src1_i[muldiv_pkg::XLEN-1], src1_i};
            src2_q <= {src2_signed & src2_i[muldiv_pkg::XLEN-1], src2_i};
            high_q <= (op_i != muldiv_pkg::MUL);
        end
        product_q <= full[2*muldiv_pkg::XLEN-1:0];
    end

    assign rslt_o = high_q ? product_q[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN]
                           : product_q[muldiv_pkg::XLEN-1:0];

endmodule

// File: rtl/div_datapath.sv
//----------------------------------------------------------------------------
// Restoring shift-subtract divider on operand magnitudes
// Sign fix-up of quotient and remainder at the output
//----------------------------------------------------------------------------
`timescale 1ns/10ps

module div_datapath (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        load_i,
    input  logic                        prep_i,
    input  logic                        zero_fix_i,
    input  logic                        step_i,
    input  muldiv_pkg::md_op_e          op_i,
    input  logic [muldiv_pkg::XLEN-1:0] src1_i,
    input  logic [muldiv_pkg::XLEN-1:0] src2_i,
    output logic                        divisor_zero_o,
    output logic [muldiv_pkg::XLEN-1:0] rslt_o
);

    logic                        is_signed;
    logic                        is_rem_q;
    logic                        dvd_neg_q;
    logic                        dvs_neg_q;
    logic                        quo_neg_q;
    logic                        rem_neg_q;
    logic [muldiv_pkg::XLEN-1:0] divisor_q;
    logic [muldiv_pkg::XLEN-1:0] rem_q;
    logic [muldiv_pkg::XLEN-1:0] quo_q;
    logic [muldiv_pkg::XLEN:0]   shifted;
    logic [muldiv_pkg::XLEN+1:0] diff;
    logic                        fits;

    assign is_signed = ~op_i[0];                         // DIV and REM
    assign shifted   = {rem_q, quo_q[muldiv_pkg::XLEN-1]};
    assign diff      = {1'b0, shifted} - {2'b00, divisor_q};
    assign fits      = ~diff[muldiv_pkg::XLEN+1];        // No borrow

    assign divisor_zero_o = (divisor_q == '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            is_rem_q  <= 1'b0;
            dvd_neg_q <= 1'b0;
            dvs_neg_q <= 1'b0;
            quo_neg_q <= 1'b0;
            rem_neg_q <= 1'b0;
        end else if (load_i) begin
            is_rem_q  <= op_i[1];
            dvd_neg_q <= is_signed & src1_i[muldiv_pkg::XLEN-1];
            dvs_neg_q <= is_signed & src2_i[muldiv_pkg::XLEN-1];
            quo_neg_q <= is_signed & (src1_i[muldiv_pkg::XLEN-1] ^ src2_i[muldiv_pkg::XLEN-1]);
            rem_neg_q <= is_signed & src1_i[muldiv_pkg::XLEN-1];  // Follows the dividend
        end else if (zero_fix_i) begin
            quo_neg_q <= 1'b0;
            rem_neg_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            divisor_q <= src2_i;
            rem_q     <= src1_i;                             // Raw dividend until prep
            quo_q     <= '0;
        end else if (prep_i) begin
            divisor_q <= dvs_neg_q ? -divisor_q : divisor_q;
            rem_q     <= '0;
            quo_q     <= dvd_neg_q ? -rem_q : rem_q;         // Dividend shifts out of quo
        end else if (zero_fix_i) begin
            quo_q <= '1;                                     // Remainder keeps the dividend
        end else if (step_i) begin
            rem_q <= fits ? diff[muldiv_pkg::XLEN-1:0] : shifted[muldiv_pkg::XLEN-1:0];
            quo_q <= {quo_q[muldiv_pkg::XLEN-2:0], fits};
        end
    end

    always_comb begin
        if (is_rem_q) begin
            rslt_o = rem_neg_q ? -rem_q : rem_q;
        end else begin
            rslt_o = quo_neg_q ? -quo_q : quo_q;
        end
    end

endmodule

// File: rtl/md_ctrl.sv
//----------------------------------------------------------------------------
// Operation FSM steering the multiply and divide datapaths
//----------------------------------------------------------------------------
`timescale 1ns/10ps

module md_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_i,
    md_req_if.ctrl                      req,
    output logic                        mul_load_o,
    output logic                        div_load_o,
    output logic                        div_prep_o,
    output logic                        div_zero_fix_o,
    output logic                        div_step_o,
    output logic                        cnt_load_o,
    output logic                        cnt_en_o,
    input  logic                        last_i,
    input  logic                        divisor_zero_i,
    input  logic [muldiv_pkg::XLEN-1:0] mul_rslt_i,
    input  logic [muldiv_pkg::XLEN-1:0] div_rslt_i
);

    muldiv_pkg::md_state_e       state_q;
    muldiv_pkg::md_state_e       state_d;
    logic                        is_idle;
    logic                        in_check;
    logic [muldiv_pkg::XLEN-1:0] rslt_q;

    assign is_idle  = (state_q == muldiv_pkg::IDLE);
    assign in_check = (state_q == muldiv_pkg::DIV_CHECK);

    assign mul_load_o     = is_idle & req.start & ~req.op[2];
    assign div_load_o     = is_idle & req.start & req.op[2];
    assign div_prep_o     = in_check & ~divisor_zero_i;
    assign div_zero_fix_o = in_check & divisor_zero_i;   // Skips the step loop
    assign cnt_load_o     = div_prep_o;
    assign div_step_o     = (state_q == muldiv_pkg::DIV_EXEC);
    assign cnt_en_o       = div_step_o;

    assign req.busy = ~is_idle;
    assign req.rslt = rslt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            muldiv_pkg::IDLE: begin
                if (req.start) begin
                    state_d = req.op[2] ? muldiv_pkg::DIV_CHECK : muldiv_pkg::MUL_EXEC;
                end
            end
            muldiv_pkg::MUL_EXEC:  state_d = muldiv_pkg::RET;  // Product registers here
            muldiv_pkg::DIV_CHECK: begin
                state_d = divisor_zero_i ? muldiv_pkg::RET : muldiv_pkg::DIV_EXEC;
            end
            muldiv_pkg::DIV_EXEC: begin
                if (last_i) begin
                    state_d = muldiv_pkg::RET;
                end
            end
            default: state_d = muldiv_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= muldiv_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == muldiv_pkg::RET) begin
            rslt_q <= req.op[2] ? div_rslt_i : mul_rslt_i;
        end
    end

endmodule

// File: rtl/apb_regs.sv
//----------------------------------------------------------------------------
// APB slave register bank: operands, command, status and result
// Wait states for CMD and RESULT while an operation runs
//----------------------------------------------------------------------------
`timescale 1ns/10ps

module apb_regs (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [muldiv_pkg::ADDR_W-1:0] paddr_i,
    input  logic [muldiv_pkg::XLEN-1:0]   pwdata_i,
    output logic [muldiv_pkg::XLEN-1:0]   prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    md_req_if.regs                        req
);

    logic                        access;
    logic                        addr_ok;
    logic                        hold;
    logic                        xfer;
    logic                        cmd_wr;
    logic [muldiv_pkg::XLEN-1:0] src1_q;
    logic [muldiv_pkg::XLEN-1:0] src2_q;
    muldiv_pkg::md_op_e          op_q;
    muldiv_pkg::md_op_e          op_wr;
    logic                        busy_q;
    logic                        done_q;

    assign access = psel_i & penable_i;  // APB access phase
    assign op_wr  = muldiv_pkg::md_op_e'(pwdata_i[2:0]);

    always_comb begin
        case (paddr_i)
            muldiv_pkg::REG_SRC1, muldiv_pkg::REG_SRC2, muldiv_pkg::REG_CMD,
            muldiv_pkg::REG_STATUS, muldiv_pkg::REG_RESULT: addr_ok = 1'b1;
            default:                                        addr_ok = 1'b0;  // Unaligned too
        endcase
    end

    // CMD writes and RESULT reads wait for the running operation
    assign hold = req.busy & (((paddr_i == muldiv_pkg::REG_CMD) & pwrite_i) |
                              ((paddr_i == muldiv_pkg::REG_RESULT) & ~pwrite_i));

    assign pready_o  = ~(access & hold);
    assign pslverr_o = access & ~addr_ok;
    assign xfer      = access & pready_o & addr_ok;
    assign cmd_wr    = xfer & pwrite_i & (paddr_i == muldiv_pkg::REG_CMD);

    assign req.start = cmd_wr;                   // Busy is low, else pready would hold
    assign req.op    = cmd_wr ? op_wr : op_q;    // Opcode visible in the launch cycle
    assign req.src1  = src1_q;
    assign req.src2  = src2_q;

    always_ff @(posedge clk_i) begin
        if (xfer & pwrite_i & (paddr_i == muldiv_pkg::REG_SRC1)) begin
            src1_q <= pwdata_i;
        end
        if (xfer & pwrite_i & (paddr_i == muldiv_pkg::REG_SRC2)) begin
            src2_q <= pwdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            op_q   <= muldiv_pkg::MUL;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            busy_q <= req.busy;
            if (cmd_wr) begin
                op_q   <= op_wr;
                done_q <= 1'b0;                  // New operation clears done
            end else if (busy_q & ~req.busy) begin
                done_q <= 1'b1;                  // Falling edge of busy
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            muldiv_pkg::REG_SRC1:   prdata_o = src1_q;
            muldiv_pkg::REG_SRC2:   prdata_o = src2_q;
            muldiv_pkg::REG_CMD:    prdata_o[2:0] = op_q;
            muldiv_pkg::REG_STATUS: prdata_o[1:0] = {done_q, req.busy};
            muldiv_pkg::REG_RESULT: prdata_o = req.rslt;
            default:                prdata_o = '0;
        endcase
    end

endmodule

// File: rtl/muldiv_top.sv
//----------------------------------------------------------------------------
// RV32M multiply and divide coprocessor with an APB slave port
//----------------------------------------------------------------------------
`timescale 1ns/10ps

module muldiv_top (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [muldiv_pkg::ADDR_W-1:0] paddr_i,
    input  logic [muldiv_pkg::XLEN-1:0]   pwdata_i,
    output logic [muldiv_pkg::XLEN-1:0]   prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o
);

    logic                        mul_load;
    logic                        div_load;
    logic                        div_prep;
    logic                        div_zero_fix;
    logic                        div_step;
    logic                        cnt_load;
    logic                        cnt_en;
    logic                        last;
    logic                        divisor_zero;
    logic [muldiv_pkg::XLEN-1:0] mul_rslt;
    logic [muldiv_pkg::XLEN-1:0] div_rslt;

    md_req_if req_if ();

    apb_regs u_apb_regs (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .req       (req_if.regs)
    );

    md_ctrl u_md_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req            (req_if.ctrl),
        .mul_load_o     (mul_load),
        .div_load_o     (div_load),
        .div_prep_o     (div_prep),
        .div_zero_fix_o (div_zero_fix),
        .div_step_o     (div_step),
        .cnt_load_o     (cnt_load),
        .cnt_en_o       (cnt_en),
        .last_i         (last),
        .divisor_zero_i (divisor_zero),
        .mul_rslt_i     (mul_rslt),
        .div_rslt_i     (div_rslt)
    );

    step_counter u_step_counter (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .load_i (cnt_load),
        .en_i   (cnt_en),
        .last_o (last)
    );

    div_datapath u_div_datapath (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .load_i         (div_load),
        .prep_i         (div_prep),
        .zero_fix_i     (div_zero_fix),
        .step_i         (div_step),
        .op_i           (req_if.op),
        .src1_i         (req_if.src1),
        .src2_i         (req_if.src2),
        .divisor_zero_o (divisor_zero),
        .rslt_o         (div_rslt)
    );

    mul_datapath u_mul_datapath (
        .clk_i  (clk_i),
        .load_i (mul_load),
        .op_i   (req_if.op),
        .src1_i (req_if.src1),
        .src2_i (req_if.src2),
        .rslt_o (mul_rslt)
    );

endmodule

// File: test/clk_gen.sv
//----------------------------------------------------------------------------
// Testbench clock (20 ns period) and synchronous reset pulse
//----------------------------------------------------------------------------
`timescale 1ns/10ps

module clk_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD = 10;  // 20 ns clock
    localparam int RST_CYCLES  = 8;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;                 // Released on a rising edge
    end

endmodule

// File: test/tb_muldiv.sv
//----------------------------------------------------------------------------
// Testbench of the RV32M coprocessor with APB tasks, reference model,
// result comparison, timeout and final report
//----------------------------------------------------------------------------
`timescale 1ns/10ps

module tb_muldiv;

    localparam int TIMEOUT_CYCLES = 12000;  // Room for 250 ops of up to 45 cycles

    typedef struct packed {
        muldiv_pkg::md_op_e op;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        got;
    } sample_t;

    logic                          clk;
    logic                          rst;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [muldiv_pkg::ADDR_W-1:0] paddr;
    logic [31:0]                   pwdata;
    logic [31:0]                   prdata;
    logic                          pready;
    logic                          pslverr;
    sample_t                       results[$];  // Filled by stimulus, drained by compare
    int                            last_waits;
    logic                          last_err;

    clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

    muldiv_top u_muldiv_top (
        .clk_i     (clk),
        .rst_i     (rst),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    //------------------------------------------------------------------------
    // Reference model and compare
    //------------------------------------------------------------------------
    function automatic logic [31:0] ref_muldiv(muldiv_pkg::md_op_e op, logic [31:0] a,
                                               logic [31:0] b);
        logic [63:0]        ea;
        logic [63:0]        eb;
        logic [63:0]        prod;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] quo_s;
        logic signed [31:0] rem_s;
        logic [31:0]        quo_u;
        logic [31:0]        rem_u;
        ea   = (op == muldiv_pkg::MULH || op == muldiv_pkg::MULHSU) ?
               {{32{a[31]}}, a} : {32'h0, a};
        eb   = (op == muldiv_pkg::MULH) ? {{32{b[31]}}, b} : {32'h0, b};
        prod = ea * eb;                   // Low 64 bits are exact in two's complement
        sa   = a;
        sb   = b;
        if (b == 32'h0) begin             // Divide by zero
            quo_s = '1;
            rem_s = a;
            quo_u = '1;
            rem_u = a;
        end else begin
            quo_u = a / b;
            rem_u = a % b;
            if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                quo_s = sa;               // Signed overflow
                rem_s = '0;
            end else begin
                quo_s = sa / sb;
                rem_s = sa % sb;
            end
        end
        case (op)
            muldiv_pkg::MUL:  return prod[31:0];
            muldiv_pkg::DIV:  return quo_s;
            muldiv_pkg::DIVU: return quo_u;
            muldiv_pkg::REM:  return rem_s;
            muldiv_pkg::REMU: return rem_u;
            default:          return prod[63:32];
        endcase
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    initial begin : compare
        sample_t s;
        forever begin
            @(negedge clk);
            while (results.size() != 0) begin
                s = results.pop_front();
                check_equal(s.got, ref_muldiv(s.op, s.a, s.b),
                            $sformatf("%s a=%h b=%h", s.op.name(), s.a, s.b));
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: the run did not finish within %0d cycles", cycles);
                $display("TEST FAILED");
                $fatal(1, "DUT hang");
            end
        end
    end

    //------------------------------------------------------------------------
    // APB master tasks
    //------------------------------------------------------------------------
    task automatic apb_xfer(input logic wr, input logic [muldiv_pkg::ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        psel    <= 1'b1;                  // Setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;                  // Access phase
        last_waits = 0;
        @(negedge clk);
        while (!pready) begin
            last_waits++;
            @(negedge clk);
        end
        rdata    = prdata;
        last_err = pslverr;
        @(posedge clk);                   // Transfer completes here
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [muldiv_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [muldiv_pkg::ADDR_W-1:0] addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'h0, data);
    endtask

    // Runs one operation and queues its result for the compare process
    task automatic run_op(input muldiv_pkg::md_op_e op, input logic [31:0] a,
                          input logic [31:0] b);
        sample_t s;
        apb_write(muldiv_pkg::REG_SRC1, a);
        apb_write(muldiv_pkg::REG_SRC2, b);
        apb_write(muldiv_pkg::REG_CMD, {29'h0, op});
        s.op = op;
        s.a  = a;
        s.b  = b;
        apb_read(muldiv_pkg::REG_RESULT, s.got);
        results.push_back(s);
    endtask

    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $urandom;
        case (r[2:0])
            3'd0:    return 32'h8000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h0;
            3'd3:    return {{24{r[31]}}, r[31:24]};  // Small signed value
            default: return $urandom;
        endcase
    endfunction

    //------------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------------
    initial begin : stimulus
        logic [31:0] rdata;
        logic [31:0] val;
        logic [2:0]  sel;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'hf6f8de7c));
        while (rst) @(posedge clk);

        apb_read(muldiv_pkg::REG_STATUS, rdata);
        check_equal(rdata, 32'h0, "STATUS after reset");
        val = $urandom;
        apb_write(muldiv_pkg::REG_SRC1, val);
        apb_read(muldiv_pkg::REG_SRC1, rdata);
        check_equal(rdata, val, "SRC1 readback");
        val = ~val;
        apb_write(muldiv_pkg::REG_SRC2, val);
        apb_read(muldiv_pkg::REG_SRC2, rdata);
        check_equal(rdata, val, "SRC2 readback");
        check_equal({31'h0, last_err}, 32'h0, "pslverr on a mapped register");

        repeat (100) begin                // Multiply family
            sel = 3'($urandom_range(3, 0));
            run_op(muldiv_pkg::md_op_e'(sel), pick_operand(), pick_operand());
        end
        repeat (100) begin                // Divide family
            sel = 3'($urandom_range(7, 4));
            run_op(muldiv_pkg::md_op_e'(sel), pick_operand(), pick_operand());
        end

        for (int i = 4; i < 8; i++) begin
            run_op(muldiv_pkg::md_op_e'(3'(i)), $urandom, 32'h0);
            run_op(muldiv_pkg::md_op_e'(3'(i)), 32'h8000_0000, 32'hffff_ffff);
        end
        run_op(muldiv_pkg::DIV, 32'h0, 32'h0);

        // RESULT read right behind a divide must be held off
        run_op(muldiv_pkg::DIV, 32'hdead_0123, 32'h0000_0017);
        check_equal({31'h0, last_waits != 0}, 32'h1, "RESULT read wait states while busy");
        apb_read(muldiv_pkg::REG_STATUS, rdata);
        check_equal(rdata, 32'h2, "STATUS done set and busy clear");

        apb_write(muldiv_pkg::REG_SRC1, 32'h5a5a_1234);
        apb_write(5'h14, 32'hffff_ffff);
        check_equal({31'h0, last_err}, 32'h1, "pslverr on write to 0x14");
        apb_read(5'h14, rdata);
        check_equal({31'h0, last_err}, 32'h1, "pslverr on read of 0x14");
        apb_read(muldiv_pkg::REG_SRC1, rdata);
        check_equal(rdata, 32'h5a5a_1234, "SRC1 after unmapped write");

        while (results.size() != 0) @(posedge clk);
        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

// File: src.f
rtl/muldiv_pkg.sv
rtl/md_req_if.sv
rtl/step_counter.sv
rtl/mul_datapath.sv
rtl/div_datapath.sv
rtl/md_ctrl.sv
rtl/apb_regs.sv
rtl/muldiv_top.sv
test/clk_gen.sv
test/tb_muldiv.sv

// File: Makefile
# Verilator simulation of the RV32M coprocessor testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run tb_muldiv with Verilator, fail unless TEST OK is printed"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/10ps --top-module tb_muldiv -f src.f
	@out=$$(./obj_dir/Vtb_muldiv); echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
